/* build.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_reg.sv
hdl/alu.sv
hdl/operand_select.sv
hdl/next_pc_unit.sv
hdl/exu.sv
hdl/exu_top.sv
test/clock_gen.sv
test/exu_props.sv
test/exu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module exu_tb -f build.f -o exu_sim &&
  ./obj_dir/exu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" || exit 1

/* test/exu_tb.sv */
module exu_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tests = 6;
  localparam int clock_period = 40;

  logic    clock;
  logic    reset;
  logic    block;
  logic    issue_valid;
  issue_t  issue;
  word_t   fwd_data;
  logic    result_valid;
  result_t result;
  logic    flush;
  logic    clear_cache;

  int      seed = 56766;
  word_t   fwd_value;
  issue_t  slots[$];
  int      stall_slot = -1;
  int      stall_len = 0;
  result_t pend_res[$];
  bit      pend_keep[$];
  result_t exp_res[$];
  int      exp_tag[$];
  int      adv = 0;
  bit      last_adv = 0;

  clock_gen i_clock_gen (.clock(clock), .reset(reset));

  exu_top i_exu_top (
    .clock        (clock),
    .reset        (reset),
    .block        (block),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .fwd_data     (fwd_data),
    .result_valid (result_valid),
    .result       (result),
    .flush        (flush),
    .clear_cache  (clear_cache)
  );

  bind exu_top exu_props i_exu_props (.*);

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(string what, word_t got, word_t expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, expected);
      stop_run();
    end
  endtask

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    word_t y;
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sll:  y = a << b[4:0];
      alu_srl:  y = a >> b[4:0];
      alu_sra:  y = $signed(a) >>> b[4:0];
      alu_xor:  y = a ^ b;
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      alu_slt, alu_lt: y = {31'b0, $signed(a) < $signed(b)};
      alu_sltu, alu_ltu: y = {31'b0, a < b};
      alu_eq:   y = {31'b0, a == b};
      alu_ne:   y = {31'b0, a != b};
      alu_ge:   y = {31'b0, $signed(a) >= $signed(b)};
      alu_geu:  y = {31'b0, a >= b};
      alu_pass_b: y = b;
      default:  y = '0;
    endcase
    return y;
  endfunction

  // expected result of one instruction from the selection rules
  function automatic result_t model(issue_t ins, word_t prev_rd, word_t fwd);
    word_t   a;
    word_t   b;
    word_t   st;
    word_t   y;
    word_t   snpc;
    word_t   dnpc;
    result_t r;
    a = (ins.src1_sel == src1_prev) ? prev_rd : (ins.src1_sel == src1_fwd) ? fwd : ins.src1;
    st = (ins.src2_sel == src2_prev) ? prev_rd : (ins.src2_sel == src2_fwd) ? fwd : ins.src2;
    b = (ins.src2_sel == src2_imm) ? ins.imm : (ins.src2_sel == src2_csr) ? ins.csr_src : st;
    y = alu_model(ins.alu_op, a, b);
    snpc = ins.pc + 32'd4;
    dnpc = ins.pc + ins.imm;
    case (ins.npc_sel)
      npc_jal:    r.npc = dnpc;
      npc_jalr:   r.npc = y & 32'hffff_fffe;
      npc_branch: r.npc = y[0] ? dnpc : snpc;
      npc_trap:   r.npc = ins.csr_src;
      default:    r.npc = snpc;
    endcase
    case (ins.wb_sel)
      wb_snpc: r.rd_data = snpc;
      wb_dnpc: r.rd_data = dnpc;
      wb_csr:  r.rd_data = ins.csr_src;
      default: r.rd_data = y;
    endcase
    r.store_data = st;
    r.redirect = ins.npc_sel != npc_seq;
    r.csr_wdata1 = ins.cause_sel ? 32'd11 : y;
    r.csr_wdata2 = ins.pc;
    r.fence_i = ins.fence_i;
    return r;
  endfunction

  // execute holds the oldest expected result one advancing edge before it retires
  function automatic bit flush_due();
    if (exp_res.size() == 0 || exp_tag[0] != adv + 1) begin
      return 1'b0;
    end
    return exp_res[0].redirect || exp_res[0].fence_i;
  endfunction

  function automatic issue_t make_op(alu_op_e op, word_t a, word_t b);
    issue_t ins;
    ins = '0;
    ins.pc = $random(seed) & 32'hffff_fffc;
    ins.imm = $random(seed);
    ins.csr_src = $random(seed);
    ins.src1 = a;
    ins.src2 = b;
    ins.alu_op = op;
    return ins;
  endfunction

  function automatic issue_t filler();
    return make_op(alu_add, $random(seed), $random(seed));
  endfunction

  // drive the queued slots back to back, then wait for the pipe to drain
  task automatic run_stream();
    word_t   prev_rd;
    result_t r;
    bit      ctl1;
    bit      ctl2;
    bit      keep;
    int      waited;
    prev_rd = '0;
    ctl1 = 0;
    ctl2 = 0;
    for (int i = 0; i < slots.size(); i++) begin
      if (i == stall_slot) begin
        @(posedge clock);
        block <= 1'b1;
        repeat (stall_len - 1) @(posedge clock);
      end
      keep = !ctl1 && !ctl2;
      r = model(slots[i], prev_rd, fwd_value);
      prev_rd = r.rd_data;
      ctl2 = ctl1;
      ctl1 = keep && (slots[i].npc_sel != npc_seq || slots[i].fence_i);
      @(posedge clock);
      block <= 1'b0;
      issue_valid <= 1'b1;
      issue <= slots[i];
      pend_res.push_back(r);
      pend_keep.push_back(keep);
    end
    @(posedge clock);
    issue_valid <= 1'b0;
    waited = 0;
    while ((pend_res.size() != 0 || exp_res.size() != 0) && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (pend_res.size() != 0 || exp_res.size() != 0) begin
      $display("expected results did not arrive after the stream");
      stop_run();
    end
    repeat (3) @(posedge clock);
    slots.delete();
    stall_slot = -1;
  endtask

  task automatic set_forward(word_t value);
    fwd_value = value;
    @(posedge clock);
    fwd_data <= value;
  endtask

  task automatic test_alu_ops();
    issue_t ins;
    word_t  v;
    for (int k = 0; k < 17; k++) begin
      slots.push_back(make_op(alu_op_e'(k), $random(seed), $random(seed)));
      ins = make_op(alu_op_e'(k), $random(seed), $random(seed));
      ins.src2_sel = src2_imm;
      slots.push_back(ins);
      // equal operands so eq, ge and geu also give 1
      v = $random(seed);
      slots.push_back(make_op(alu_op_e'(k), v, v));
    end
    run_stream();
  endtask

  task automatic test_forwarding();
    issue_t ins;
    set_forward($random(seed));
    slots.push_back(make_op(alu_add, $random(seed), $random(seed)));
    ins = make_op(alu_add, '0, '0);
    ins.src1_sel = src1_prev;
    ins.src2_sel = src2_fwd;
    slots.push_back(ins);
    ins = make_op(alu_sub, '0, '0);
    ins.src1_sel = src1_fwd;
    ins.src2_sel = src2_prev;
    slots.push_back(ins);
    ins = make_op(alu_xor, '0, $random(seed));
    ins.src1_sel = src1_prev;
    ins.src2_sel = src2_imm;
    slots.push_back(ins);
    ins = make_op(alu_or, '0, $random(seed));
    ins.src1_sel = src1_prev;
    ins.src2_sel = src2_csr;
    slots.push_back(ins);
    ins = make_op(alu_pass_b, $random(seed), '0);
    ins.src2_sel = src2_prev;
    slots.push_back(ins);
    run_stream();
  endtask

  function automatic issue_t control(int kind);
    issue_t ins;
    word_t  v;
    v = $random(seed);
    ins = make_op(alu_eq, v, v);
    ins.imm = $random(seed) & 32'hffff_fffe;
    case (kind)
      0: begin
        ins.npc_sel = npc_jal;
        ins.wb_sel = wb_snpc;
      end
      1: begin
        // odd target so that bit 0 gets cleared
        ins.alu_op = alu_add;
        ins.src1 = v & 32'hffff_fffe;
        ins.imm = ins.imm | 32'd1;
        ins.src2_sel = src2_imm;
        ins.npc_sel = npc_jalr;
        ins.wb_sel = wb_snpc;
      end
      2: begin
        ins.npc_sel = npc_branch;
        ins.wb_sel = wb_dnpc;
      end
      3: begin
        ins.src2 = v + 32'd1;
        ins.npc_sel = npc_branch;
      end
      default: begin
        ins.npc_sel = npc_trap;
        ins.wb_sel = wb_csr;
      end
    endcase
    return ins;
  endfunction

  task automatic test_next_pc();
    for (int k = 0; k < 5; k++) begin
      slots.push_back(control(k));
      run_stream();
    end
  endtask

  task automatic test_flush();
    for (int k = 0; k < 5; k++) begin
      slots.push_back(control(k));
      repeat (3) slots.push_back(filler());
    end
    run_stream();
  endtask

  task automatic test_csr_fence();
    issue_t ins;
    ins = make_op(alu_add, $random(seed), $random(seed));
    ins.cause_sel = 1'b1;
    ins.npc_sel = npc_trap;
    slots.push_back(ins);
    repeat (2) slots.push_back(filler());
    ins = make_op(alu_or, $random(seed), '0);
    ins.src2_sel = src2_csr;
    ins.wb_sel = wb_csr;
    slots.push_back(ins);
    ins = filler();
    ins.fence_i = 1'b1;
    slots.push_back(ins);
    repeat (3) slots.push_back(filler());
    run_stream();
  endtask

  task automatic test_block();
    issue_t ins;
    repeat (4) slots.push_back(filler());
    ins = make_op(alu_add, '0, $random(seed));
    ins.src1_sel = src1_prev;
    slots.push_back(ins);
    repeat (3) slots.push_back(filler());
    stall_slot = 4;
    stall_len = 5;
    run_stream();
  endtask

  // results sampled on the falling edge between drive edges
  always @(negedge clock) begin
    if (reset) begin
      last_adv = 0;
    end else begin
      if (result_valid && last_adv) begin
        if (exp_res.size() == 0) begin
          $display("a result appeared where none was expected");
          stop_run();
        end else begin
          check("rd_data", result.rd_data, exp_res[0].rd_data);
          check("store_data", result.store_data, exp_res[0].store_data);
          check("npc", result.npc, exp_res[0].npc);
          check("redirect", word_t'(result.redirect), word_t'(exp_res[0].redirect));
          check("csr_wdata1", result.csr_wdata1, exp_res[0].csr_wdata1);
          check("csr_wdata2", result.csr_wdata2, exp_res[0].csr_wdata2);
          check("clear_cache", word_t'(clear_cache), word_t'(exp_res[0].fence_i));
          check("latency", word_t'(adv), word_t'(exp_tag[0]));
          void'(exp_res.pop_front());
          void'(exp_tag.pop_front());
        end
      end
      if (!result_valid) begin
        check("clear_cache idle", word_t'(clear_cache), '0);
      end
      check("flush", word_t'(flush), word_t'(flush_due()));
      if (!block) begin
        adv++;
        if (issue_valid && pend_res.size() != 0) begin
          if (pend_keep[0]) begin
            exp_res.push_back(pend_res[0]);
            exp_tag.push_back(adv + 2);
          end
          void'(pend_res.pop_front());
          void'(pend_keep.pop_front());
        end
      end
      last_adv = !block;
    end
  end

  initial begin
    #(n_tests * 200 * clock_period);
    $display("watchdog expired before the tests finished");
    stop_run();
  end

  initial begin
    block = 1'b0;
    issue_valid = 1'b0;
    issue = '0;
    fwd_data = '0;
    fwd_value = '0;
    @(negedge reset);
    @(posedge clock);
    test_alu_ops();
    test_forwarding();
    test_next_pc();
    test_flush();
    test_csr_fence();
    test_block();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* test/exu_props.sv */
module exu_props
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input logic    clock,
  input logic    reset,
  input logic    block,
  input logic    result_valid,
  input result_t result,
  input logic    flush,
  input logic    clear_cache
);

  timeunit 1ns;
  timeprecision 1ps;

  // outputs quiet once reset has been seen
  assert property (@(posedge clock)
    $past(reset) |-> !result_valid && !flush && !clear_cache)
    else $error("outputs active during reset");

  assert property (@(posedge clock) disable iff (reset)
    clear_cache && !block |=> !clear_cache)
    else $error("clear_cache longer than one cycle");

  // a fresh redirecting result was flushing one edge before
  assert property (@(posedge clock) disable iff (reset)
    result_valid && result.redirect && !$past(block) |-> $past(flush))
    else $error("redirect result without flush");

endmodule

/* test/clock_gen.sv */
module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // reset spans the first 4 rising edges
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

/* hdl/exu_top.sv */
module exu_top
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    block,
  input  logic    issue_valid,
  input  issue_t  issue,
  input  word_t   fwd_data,
  output logic    result_valid,
  output result_t result,
  output logic    flush,
  output logic    clear_cache
);

  logic    id_valid;
  issue_t  id_issue;
  logic    ex_valid;
  result_t ex_result;

  stage_reg #(.payload_t(issue_t)) i_issue_reg (
    .clock     (clock),
    .reset     (reset),
    .hold      (block),
    .squash    (flush),
    .in_valid  (issue_valid),
    .in_data   (issue),
    .out_valid (id_valid),
    .out_data  (id_issue)
  );

  exu i_exu (
    .clock      (clock),
    .reset      (reset),
    .block      (block),
    .in_valid   (id_valid),
    .in_issue   (id_issue),
    .fwd_data   (fwd_data),
    .out_valid  (ex_valid),
    .out_result (ex_result),
    .flush      (flush)
  );

  // the flushing instruction itself must retire
  stage_reg #(.payload_t(result_t)) i_result_reg (
    .clock     (clock),
    .reset     (reset),
    .hold      (block),
    .squash    (1'b0),
    .in_valid  (ex_valid),
    .in_data   (ex_result),
    .out_valid (result_valid),
    .out_data  (result)
  );

  assign clear_cache = result_valid && result.fence_i;

endmodule

/* hdl/exu.sv */
module exu
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    block,
  input  logic    in_valid,
  input  issue_t  in_issue,
  input  word_t   fwd_data,
  output logic    out_valid,
  output result_t out_result,
  output logic    flush
);

  logic   ex_valid;
  issue_t ex_issue;
  word_t  op_a;
  word_t  op_b;
  word_t  store_data;
  word_t  alu_y;
  word_t  snpc;
  word_t  dnpc;
  word_t  npc;
  logic   redirect;
  word_t  rd_data;

  operand_select i_operand_select (
    .clock       (clock),
    .reset       (reset),
    .hold        (block),
    .squash      (flush),
    .in_valid    (in_valid),
    .in_issue    (in_issue),
    .prev_result (rd_data),
    .fwd_data    (fwd_data),
    .ex_valid    (ex_valid),
    .ex_issue    (ex_issue),
    .op_a        (op_a),
    .op_b        (op_b),
    .store_data  (store_data)
  );

  alu i_alu (
    .op (ex_issue.alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  next_pc_unit i_next_pc_unit (
    .ex_valid (ex_valid),
    .ex_issue (ex_issue),
    .alu_y    (alu_y),
    .snpc     (snpc),
    .dnpc     (dnpc),
    .npc      (npc),
    .redirect (redirect),
    .flush    (flush)
  );

  // snpc for jal/jalr link, dnpc for auipc, csr_src for csr reads
  always_comb begin
    case (ex_issue.wb_sel)
      wb_snpc: rd_data = snpc;
      wb_dnpc: rd_data = dnpc;
      wb_csr:  rd_data = ex_issue.csr_src;
      default: rd_data = alu_y;
    endcase
  end

  assign out_valid = ex_valid;

  always_comb begin
    out_result.rd_data    = rd_data;
    out_result.store_data = store_data;
    out_result.npc        = npc;
    out_result.redirect   = redirect;
    // mcause on ecall, otherwise the csr op result
    out_result.csr_wdata1 = ex_issue.cause_sel ? ecall_cause : alu_y;
    // mepc
    out_result.csr_wdata2 = ex_issue.pc;
    out_result.fence_i    = ex_issue.fence_i;
  end

endmodule

/* hdl/next_pc_unit.sv */
module next_pc_unit
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic   ex_valid,
  input  issue_t ex_issue,
  input  word_t  alu_y,
  output word_t  snpc,
  output word_t  dnpc,
  output word_t  npc,
  output logic   redirect,
  output logic   flush
);

  logic taken;

  assign snpc  = ex_issue.pc + pc_step;
  assign dnpc  = ex_issue.pc + ex_issue.imm;

  // compare result from the alu
  assign taken = alu_y[0];

  always_comb begin
    case (ex_issue.npc_sel)
      npc_jal:    npc = dnpc;
      npc_jalr:   npc = {alu_y[31:1], 1'b0};
      npc_branch: npc = taken ? dnpc : snpc;
      // trap entry or return, target comes from mtvec or mepc
      npc_trap:   npc = ex_issue.csr_src;
      default:    npc = snpc;
    endcase
  end

  // a not-taken branch still redirects to snpc
  assign redirect = ex_issue.npc_sel != npc_seq;

  // fence.i also restarts fetch behind it
  assign flush = ex_valid && (redirect || ex_issue.fence_i);

endmodule

/* hdl/operand_select.sv */
module operand_select
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   hold,
  input  logic   squash,
  input  logic   in_valid,
  input  issue_t in_issue,
  input  word_t  prev_result,
  input  word_t  fwd_data,
  output logic   ex_valid,
  output issue_t ex_issue,
  output word_t  op_a,
  output word_t  op_b,
  output word_t  store_data
);

  word_t a_next;
  word_t b_next;
  word_t store_next;

  always_comb begin
    case (in_issue.src1_sel)
      src1_prev: a_next = prev_result;
      src1_fwd:  a_next = fwd_data;
      default:   a_next = in_issue.src1;
    endcase
  end

  // store data sees the same forwarding but never imm or csr
  always_comb begin
    case (in_issue.src2_sel)
      src2_prev: store_next = prev_result;
      src2_fwd:  store_next = fwd_data;
      default:   store_next = in_issue.src2;
    endcase
  end

  always_comb begin
    case (in_issue.src2_sel)
      src2_imm: b_next = in_issue.imm;
      src2_csr: b_next = in_issue.csr_src;
      default:  b_next = store_next;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (!hold) begin
      ex_valid <= in_valid && !squash;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      ex_issue   <= in_issue;
      op_a       <= a_next;
      op_b       <= b_next;
      store_data <= store_next;
    end
  end

endmodule

/* hdl/alu.sv */
module alu
  import isa_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   y
);

  logic [shamt_bits-1:0] shamt;
  logic                  lt_s;
  logic                  lt_u;
  logic                  eq;

  assign shamt = b[shamt_bits-1:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = {31'b0, lt_s};
      alu_sltu:   y = {31'b0, lt_u};
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = $signed(a) >>> shamt;
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      // branch compares, bit 0 is the taken flag
      alu_eq:     y = {31'b0, eq};
      alu_ne:     y = {31'b0, !eq};
      alu_lt:     y = {31'b0, lt_s};
      alu_ge:     y = {31'b0, !lt_s};
      alu_ltu:    y = {31'b0, lt_u};
      alu_geu:    y = {31'b0, !lt_u};
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

/* hdl/stage_reg.sv */
module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     hold,
  input  logic     squash,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // hold wins over squash, so a blocked pipe keeps its contents
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= in_valid && !squash;
    end
  end

  // payload follows the input even when squashed
  always_ff @(posedge clock) begin
    if (!hold) begin
      out_data <= in_data;
    end
  end

endmodule

/* hdl/pipe_pkg.sv */
package pipe_pkg;

  import isa_pkg::*;

  typedef enum logic [2:0] {
    npc_seq    = 3'd0,
    npc_jal    = 3'd1,
    npc_jalr   = 3'd2,
    npc_branch = 3'd3,
    npc_trap   = 3'd4
  } npc_sel_e;

  // register write back source
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_snpc = 2'd1,
    wb_dnpc = 2'd2,
    wb_csr  = 2'd3
  } wb_sel_e;

  // prev is the last execute result, fwd the external forward
  typedef enum logic [1:0] {
    src1_reg  = 2'd0,
    src1_prev = 2'd1,
    src1_fwd  = 2'd2
  } src1_sel_e;

  typedef enum logic [2:0] {
    src2_reg  = 3'd0,
    src2_imm  = 3'd1,
    src2_csr  = 3'd2,
    src2_prev = 3'd3,
    src2_fwd  = 3'd4
  } src2_sel_e;

  typedef struct packed {
    word_t     pc;
    word_t     imm;
    word_t     src1;
    word_t     src2;
    word_t     csr_src;
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    npc_sel_e  npc_sel;
    wb_sel_e   wb_sel;
    logic      cause_sel;
    logic      fence_i;
  } issue_t;

  typedef struct packed {
    word_t rd_data;
    word_t store_data;
    word_t npc;
    logic  redirect;
    word_t csr_wdata1;
    word_t csr_wdata2;
    logic  fence_i;
  } result_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

  // one data or address word
  typedef logic [31:0] word_t;

  // alu operation codes
  // compares give 0 or 1 in the low bit
  typedef enum logic [7:0] {
    alu_add    = 8'd0,
    alu_sub    = 8'd1,
    alu_sll    = 8'd2,
    alu_slt    = 8'd3,
    alu_sltu   = 8'd4,
    alu_xor    = 8'd5,
    alu_srl    = 8'd6,
    alu_sra    = 8'd7,
    alu_or     = 8'd8,
    alu_and    = 8'd9,
    alu_eq     = 8'd10,
    alu_ne     = 8'd11,
    alu_lt     = 8'd12,
    alu_ge     = 8'd13,
    alu_ltu    = 8'd14,
    alu_geu    = 8'd15,
    alu_pass_b = 8'd16
  } alu_op_e;

  // width of one instruction in bytes
  localparam word_t pc_step = 32'd4;

  // machine mode ecall, goes to mcause
  localparam word_t ecall_cause = 32'd11;

  // shift amount field of the second operand
  localparam int shamt_bits = 5;

endpackage
